// File: build.f
+incdir+.
display_pkg.sv
display_if.sv
scanTimer.sv
boomGenerator.sv
overlayRegs.sv
pixelMixer.sv
displayTop.sv
displayTop_assert.sv
tb_displayTop.sv

// File: Makefile
# Verilator build and run for the BOOM overlay testbench
TOP ?= tb_displayTop
LOG ?= sim.log
SEED ?= 26662
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	elif grep -q "Simulation PASSED" $(LOG); then \
	  echo "PASS: see $(LOG)"; \
	else \
	  echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_displayTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "boom_config.svh"

module tb_displayTop;
  import display_pkg::*;

  localparam int numSteps = 4;
  localparam int maxWrites = 3;
  localparam int numProbes = 16;

  // frames watched after each configuration step
  localparam int stepFrames [numSteps] = '{2, 2, 6, 2};

  // probe points and their expected hit bits from the stroke rules
  localparam int probeX [numProbes] = '{86, 85, 86, 88, 84, 84, 82, 82,
                                        142, 141, 208, 208, 221, 221, 20, 300};
  localparam int probeY [numProbes] = '{140, 140, 138, 138, 99, 98, 101, 100,
                                        98, 98, 119, 117, 136, 137, 20, 200};
  localparam bit probeHit [numProbes] = '{1, 0, 0, 1, 1, 0, 1, 0,
                                          1, 0, 1, 0, 1, 0, 0, 0};

  // every pixel outside the artwork extent is a miss
  localparam int bannerWidth = 146;
  localparam int bannerHeight = 47;

  logic clk;
  logic nrst;
  logic cfgWrite;
  cfgAddr_t cfgAddr;
  cfgData_t cfgData;
  logic hsync;
  logic vsync;
  logic de;
  color_t color;

  int stepWrites [numSteps];
  cfgAddr_t stepAddr [numSteps][maxWrites];
  cfgData_t stepData [numSteps][maxWrites];

  // register model
  // blinkFrame counts frames since the last period write
  logic modelEnable;
  color_t modelBoom;
  color_t modelBg;
  blinkPeriod_t modelPeriod;
  int blinkFrame;

  // pixel tracking state
  logic monitorOn;
  logic synced;
  logic prevDe;
  logic prevHsync;
  logic prevVsync;
  int colIdx;
  int rowIdx;
  int hsyncLow;
  int vsyncLow;
  int errorCount;
  event frameEdge;

  displayTop uut (
    .clk(clk),
    .nrst(nrst),
    .cfgWrite(cfgWrite),
    .cfgAddr(cfgAddr),
    .cfgData(cfgData),
    .hsync(hsync),
    .vsync(vsync),
    .de(de),
    .color(color)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic checkIdle();
    checkValue("de", de, 1'b0);
    checkValue("color", color, 3'd0);
    checkValue("hsync", hsync, 1'b1);
    checkValue("vsync", vsync, 1'b1);
  endtask

  task automatic addWrite(input int s, input cfgAddr_t addr, input cfgData_t data);
    stepAddr[s][stepWrites[s]] = addr;
    stepData[s][stepWrites[s]] = data;
    stepWrites[s]++;
  endtask

  task automatic buildTable();
    color_t bg;
    color_t boomA;
    color_t boomB;
    bg = color_t'($urandom);
    boomA = color_t'($urandom);
    while (boomA == bg) boomA = color_t'($urandom);
    boomB = color_t'($urandom);
    while ((boomB == bg) || (boomB == boomA)) boomB = color_t'($urandom);
    for (int s = 0; s < numSteps; s++) begin
      stepWrites[s] = 0;
    end
    // banner off on a random background with random unused data bits
    addWrite(0, addrBgColor, {5'($urandom), bg});
    addWrite(0, addrEnable, 8'h00);
    addWrite(0, addrBlinkPeriod, 8'h00);
    addWrite(1, addrBoomColor, {5'($urandom), boomA});
    addWrite(1, addrEnable, 8'h01);
    addWrite(2, addrBlinkPeriod, 8'h02);
    // new colour mid run with blinking off again
    addWrite(3, addrBoomColor, {5'($urandom), boomB});
    addWrite(3, addrBlinkPeriod, 8'h00);
  endtask

  task automatic applyWrite(input cfgAddr_t addr, input cfgData_t data);
    @(posedge clk);
    cfgWrite <= 1'b1;
    cfgAddr <= addr;
    cfgData <= data;
    @(posedge clk);
    cfgWrite <= 1'b0;
    case (addr)
      addrEnable: modelEnable = data[0];
      addrBoomColor: modelBoom = data[2:0];
      addrBgColor: modelBg = data[2:0];
      addrBlinkPeriod: begin
        modelPeriod = data[3:0];
        blinkFrame = 0;
      end
    endcase
  endtask

  // expected colour of an active pixel or -1 where the model makes no claim
  function automatic int expectedColor(input int x, input int y);
    logic showing;
    logic outside;
    showing = modelEnable &&
              ((modelPeriod == 0) || (((blinkFrame / int'(modelPeriod)) % 2) == 0));
    outside = (x < `BOOM_X0) || (x >= `BOOM_X0 + bannerWidth) ||
              (y < `BOOM_Y0) || (y >= `BOOM_Y0 + bannerHeight);
    if (!showing || outside) return int'(modelBg);
    for (int i = 0; i < numProbes; i++) begin
      if ((probeX[i] == x) && (probeY[i] == y)) begin
        return probeHit[i] ? int'(modelBoom) : int'(modelBg);
      end
    end
    return -1;
  endfunction

  // position is rebuilt from de and vsync so the output latency drops out
  always @(negedge clk) begin
    int expColor;
    if (monitorOn) begin
      if (!de) begin
        checkValue("color while de low", color, 3'd0);
      end else begin
        checkValue("hsync while de high", hsync, 1'b1);
      end
      if (!hsync) begin
        hsyncLow++;
      end else if (!prevHsync) begin
        checkValue("hsync low clocks", hsyncLow, `HSYNC_LEN);
        hsyncLow = 0;
      end
      if (!vsync) begin
        vsyncLow++;
      end else if (!prevVsync) begin
        checkValue("vsync low clocks", vsyncLow, `VSYNC_LEN * `H_TOTAL);
        vsyncLow = 0;
      end
      if (synced && de) begin
        expColor = expectedColor(colIdx, rowIdx);
        if ((expColor >= 0) && (color !== color_t'(expColor))) begin
          checkValue($sformatf("color at (%0d,%0d)", colIdx, rowIdx), color, expColor);
        end
        colIdx++;
      end
      if (synced && !de && prevDe) begin
        checkValue("de pixels per line", colIdx, `H_ACTIVE);
        colIdx = 0;
        rowIdx++;
      end
      if (!vsync && prevVsync) begin
        if (synced) checkValue("de lines per frame", rowIdx, `V_ACTIVE);
        synced = 1'b1;
        rowIdx = 0;
        colIdx = 0;
        blinkFrame++;
        ->frameEdge;
      end
    end
    prevDe = de;
    prevHsync = hsync;
    prevVsync = vsync;
  end

  initial begin
    nrst = 1'b0;
    cfgWrite = 1'b0;
    cfgAddr = '0;
    cfgData = '0;
    monitorOn = 1'b0;
    synced = 1'b0;
    prevDe = 1'b0;
    prevHsync = 1'b1;
    prevVsync = 1'b1;
    colIdx = 0;
    rowIdx = 0;
    hsyncLow = 0;
    vsyncLow = 0;
    errorCount = 0;
    modelEnable = 1'b0;
    modelBoom = 3'd7;
    modelBg = 3'd0;
    modelPeriod = '0;
    blinkFrame = 0;
    void'($urandom(26662));
    buildTable();
    // outputs idle through reset and the two pipeline cycles after it
    for (int cyc = 0; cyc < 16; cyc++) begin
      @(posedge clk);
      if (cyc == 15) nrst <= 1'b1;
      @(negedge clk);
      checkIdle();
    end
    monitorOn = 1'b1;
    @(posedge clk);
    @(negedge clk);
    checkIdle();
    // the first partial frame only brings the tracker in step
    @(frameEdge);
    for (int s = 0; s < numSteps; s++) begin
      for (int w = 0; w < stepWrites[s]; w++) begin
        applyWrite(stepAddr[s][w], stepData[s][w]);
      end
      repeat (stepFrames[s]) @(frameEdge);
    end
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    longint limitNs;
    limitNs = 2;
    for (int s = 0; s < numSteps; s++) begin
      limitNs += stepFrames[s];
    end
    limitNs = limitNs * `H_TOTAL * `V_TOTAL * 10;
    #(limitNs);
    $display("timeout: the run did not finish within %0d ns", limitNs);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: displayTop_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "boom_config.svh"

module displayTop_assert (
  input logic clk,
  input logic nrst,
  input logic hsync,
  input logic vsync,
  input logic de,
  input display_pkg::color_t color
);

  // clocks spent with vsync low in the current pulse
  int vsyncLowCount;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      vsyncLowCount <= 0;
    end else if (!vsync) begin
      vsyncLowCount <= vsyncLowCount + 1;
    end else begin
      vsyncLowCount <= 0;
    end
  end

  blankIsBlack: assert property (@(posedge clk) disable iff (!nrst) !de |-> (color == '0))
    else $error("color is not black while de is low");

  noSyncInActive: assert property (@(posedge clk) disable iff (!nrst) de |-> hsync)
    else $error("hsync is low while de is high");

  // the pulse must cover exactly VSYNC_LEN whole lines
  vsyncWidth: assert property (@(posedge clk) disable iff (!nrst)
      $rose(vsync) |-> (vsyncLowCount == `VSYNC_LEN * `H_TOTAL))
    else $error("vsync pulse is not %0d lines long", `VSYNC_LEN);

endmodule

bind displayTop displayTop_assert uAssert (
  .clk(clk),
  .nrst(nrst),
  .hsync(hsync),
  .vsync(vsync),
  .de(de),
  .color(color)
);

`default_nettype wire

// File: displayTop.sv
`timescale 1ns/1ps
`default_nettype none

module displayTop (
  input logic clk,
  input logic nrst,
  input logic cfgWrite,
  input display_pkg::cfgAddr_t cfgAddr,
  input display_pkg::cfgData_t cfgData,
  output logic hsync,
  output logic vsync,
  output logic de,
  output display_pkg::color_t color
);

  pixelBus pixBus ();
  overlayCfg ovlCfg ();

  logic boomPixel;
  logic blinkRestart;

  // scan position and syncs
  scanTimer uTimer (
    .clk(clk),
    .nrst(nrst),
    .bus(pixBus)
  );

  // banner hit, one cycle behind the scan position
  boomGenerator uBoom (
    .clk(clk),
    .nrst(nrst),
    .bus(pixBus),
    .boomPixel(boomPixel)
  );

  overlayRegs uRegs (
    .clk(clk),
    .nrst(nrst),
    .cfgWrite(cfgWrite),
    .cfgAddr(cfgAddr),
    .cfgData(cfgData),
    .cfg(ovlCfg),
    .blinkRestart(blinkRestart)
  );

  // output stage, two cycles behind the scan position
  pixelMixer uMixer (
    .clk(clk),
    .nrst(nrst),
    .bus(pixBus),
    .cfg(ovlCfg),
    .boomPixel(boomPixel),
    .blinkRestart(blinkRestart),
    .hsync(hsync),
    .vsync(vsync),
    .de(de),
    .color(color)
  );

endmodule

`default_nettype wire

// File: pixelMixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixelMixer (
  input logic clk,
  input logic nrst,
  pixelBus.mix bus,
  overlayCfg.mix cfg,
  input logic boomPixel,
  input logic blinkRestart,
  output logic hsync,
  output logic vsync,
  output logic de,
  output display_pkg::color_t color
);
  import display_pkg::*;

  blinkPeriod_t frameCount;
  logic visible;
  logic showBanner;

  // scan signals delayed to line up with boomPixel
  logic activeD;
  logic hsyncD;
  logic vsyncD;

  color_t pixelColor;

  // frames shown since the last toggle, 0 right after a restart so the
  // partial frame of the write does not count
  always_ff @(posedge clk) begin
    if (!nrst) begin
      frameCount <= '0;
      visible <= 1'b1;
    end else if (blinkRestart) begin
      frameCount <= '0;
      visible <= 1'b1;
    end else if (bus.frameStart && (cfg.blinkPeriod != '0)) begin
      if (frameCount == cfg.blinkPeriod) begin
        frameCount <= blinkPeriod_t'(1);
        visible <= !visible;
      end else begin
        frameCount <= frameCount + 1'b1;
      end
    end
  end

  assign showBanner = cfg.enable && (visible || (cfg.blinkPeriod == '0));

  always_ff @(posedge clk) begin
    if (!nrst) begin
      activeD <= 1'b0;
      hsyncD <= 1'b1;
      vsyncD <= 1'b1;
    end else begin
      activeD <= bus.active;
      hsyncD <= bus.hsync;
      vsyncD <= bus.vsync;
    end
  end

  // blanking forces black
  always_comb begin
    if (!activeD) begin
      pixelColor = '0;
    end else if (showBanner && boomPixel) begin
      pixelColor = cfg.boomColor;
    end else begin
      pixelColor = cfg.bgColor;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      de <= 1'b0;
      color <= '0;
    end else begin
      hsync <= hsyncD;
      vsync <= vsyncD;
      de <= activeD;
      color <= pixelColor;
    end
  end

endmodule

`default_nettype wire

// File: overlayRegs.sv
`timescale 1ns/1ps
`default_nettype none

module overlayRegs (
  input logic clk,
  input logic nrst,
  input logic cfgWrite,
  input display_pkg::cfgAddr_t cfgAddr,
  input display_pkg::cfgData_t cfgData,
  overlayCfg.regs cfg,
  output logic blinkRestart
);
  import display_pkg::*;

  logic writeEnable;
  logic writeBoomColor;
  logic writeBgColor;
  logic writeBlink;

  // address decode
  assign writeEnable = cfgWrite && (cfgAddr == addrEnable);
  assign writeBoomColor = cfgWrite && (cfgAddr == addrBoomColor);
  assign writeBgColor = cfgWrite && (cfgAddr == addrBgColor);
  assign writeBlink = cfgWrite && (cfgAddr == addrBlinkPeriod);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      cfg.enable <= 1'b0;
      cfg.boomColor <= resetBoomColor;
      cfg.bgColor <= resetBgColor;
      cfg.blinkPeriod <= resetBlinkPeriod;
      blinkRestart <= 1'b0;
    end else begin
      if (writeEnable) begin
        cfg.enable <= cfgData[0];
      end
      if (writeBoomColor) begin
        cfg.boomColor <= cfgData[2:0];
      end
      if (writeBgColor) begin
        cfg.bgColor <= cfgData[2:0];
      end
      if (writeBlink) begin
        cfg.blinkPeriod <= cfgData[3:0];
      end
      // high in the same cycle the new period becomes visible
      blinkRestart <= writeBlink;
    end
  end

endmodule

`default_nettype wire

// File: boomGenerator.sv
`timescale 1ns/1ps
`default_nettype none

`include "boom_config.svh"

module boomGenerator (
  input logic clk,
  input logic nrst,
  pixelBus.gen bus,
  output logic boomPixel
);
  import display_pkg::*;

  // full strokes are 20 pixels long and 5 pixels thick
  localparam int strokeLen = 20;

  // horizontal strokes, column and row offsets from the origin
  localparam int horCol [8] = '{4, 27, 60, 60, 93, 93, 126, 126};
  localparam int horRow [8] = '{42, 42, 0, 42, 0, 42, 0, 42};

  // vertical strokes, every column is used at both rows
  localparam int verCol [8] = '{0, 23, 46, 56, 79, 89, 112, 122};
  localparam int verRow [2] = '{3, 24};

  pixelX_t relX;
  pixelY_t relY;
  logic boomDetect;

  // tapered stroke test along one axis
  // the middle line of the five is full length, the outer ones lose
  // one or two pixels at each tapered end
  function automatic logic strokeHit(
    input int along,
    input int across,
    input int alongStart,
    input int acrossStart,
    input int len,
    input logic taperLo,
    input logic taperHi
  );
    int depth;
    int taper;
    int lo;
    int hi;
    depth = across - acrossStart;
    case (depth)
      0, 4: taper = 2;
      1, 3: taper = 1;
      2: taper = 0;
      default: return 1'b0;
    endcase
    lo = alongStart + (taperLo ? taper : 0);
    hi = alongStart + len - 1 - (taperHi ? taper : 0);
    return (along >= lo) && (along <= hi);
  endfunction

  // offsets from the banner origin
  // pixels left of or above the origin wrap to large values and never hit
  assign relX = bus.x - pixelX_t'(`BOOM_X0);
  assign relY = bus.y - pixelY_t'(`BOOM_Y0);

  always_comb begin
    boomDetect = 1'b0;

    for (int i = 0; i < 8; i++) begin
      if (strokeHit(int'(relX), int'(relY), horCol[i], horRow[i], strokeLen, 1'b1, 1'b1)) begin
        boomDetect = 1'b1;
      end
    end

    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 2; j++) begin
        if (strokeHit(int'(relY), int'(relX), verRow[j], verCol[i], strokeLen,
                      1'b1, 1'b1)) begin
          boomDetect = 1'b1;
        end
      end
    end

    // lower left bar of the B, square end where it meets the middle bar
    if (strokeHit(int'(relY), int'(relX), 24, 137, 17, 1'b1, 1'b0)) begin
      boomDetect = 1'b1;
    end

    // short middle bar of the B
    if (strokeHit(int'(relX), int'(relY), 126, 21, 12, 1'b1, 1'b1)) begin
      boomDetect = 1'b1;
    end

    // upper left bar of the B, square end at the top
    if (strokeHit(int'(relY), int'(relX), 6, 137, 17, 1'b0, 1'b1)) begin
      boomDetect = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      boomPixel <= 1'b0;
    end else begin
      boomPixel <= boomDetect;
    end
  end

endmodule

`default_nettype wire

// File: scanTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "boom_config.svh"

module scanTimer (
  input logic clk,
  input logic nrst,
  pixelBus.timer bus
);
  import display_pkg::*;

  // last column and last line of the full frame
  localparam pixelX_t xLast = pixelX_t'(`H_TOTAL - 1);
  localparam pixelY_t yLast = pixelY_t'(`V_TOTAL - 1);

  // visible window
  localparam pixelX_t xActive = pixelX_t'(`H_ACTIVE);
  localparam pixelY_t yActive = pixelY_t'(`V_ACTIVE);

  // sync windows, end bound is exclusive
  localparam pixelX_t hsStart = pixelX_t'(`HSYNC_START);
  localparam pixelX_t hsEnd = pixelX_t'(`HSYNC_START + `HSYNC_LEN);
  localparam pixelY_t vsStart = pixelY_t'(`VSYNC_START);
  localparam pixelY_t vsEnd = pixelY_t'(`VSYNC_START + `VSYNC_LEN);

  logic lineEnd;
  logic frameEnd;

  assign lineEnd = (bus.x == xLast);
  assign frameEnd = (bus.y == yLast);

  // column counter runs every clock, row counter steps at the end of a line
  always_ff @(posedge clk) begin
    if (!nrst) begin
      bus.x <= '0;
      bus.y <= '0;
    end else begin
      if (lineEnd) begin
        bus.x <= '0;
        if (frameEnd) begin
          bus.y <= '0;
        end else begin
          bus.y <= bus.y + 1'b1;
        end
      end else begin
        bus.x <= bus.x + 1'b1;
      end
    end
  end

  // decodes follow the registered position in the same cycle
  assign bus.active = (bus.x < xActive) && (bus.y < yActive);

  // both syncs are active low
  assign bus.hsync = !((bus.x >= hsStart) && (bus.x < hsEnd));
  assign bus.vsync = !((bus.y >= vsStart) && (bus.y < vsEnd));

  // single clock at the top left corner
  assign bus.frameStart = (bus.x == '0) && (bus.y == '0);

endmodule

`default_nettype wire

// File: display_if.sv
`timescale 1ns/1ps
`default_nettype none

// scan position and sync levels, all driven by the scan timer
interface pixelBus;
  import display_pkg::*;

  pixelX_t x;
  pixelY_t y;
  logic active;
  logic hsync;
  logic vsync;
  logic frameStart;

  modport timer (output x, y, active, hsync, vsync, frameStart);
  modport gen (input x, y);
  modport mix (input active, hsync, vsync, frameStart);
endinterface

// overlay settings held by the register block
interface overlayCfg;
  import display_pkg::*;

  logic enable;
  color_t boomColor;
  color_t bgColor;
  blinkPeriod_t blinkPeriod;

  modport regs (output enable, boomColor, bgColor, blinkPeriod);
  modport mix (input enable, boomColor, bgColor, blinkPeriod);
endinterface

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

package display_pkg;

  // screen coordinates
  typedef logic [8:0] pixelX_t;
  typedef logic [7:0] pixelY_t;

  // one bit each for red, green and blue
  typedef logic [2:0] color_t;

  // configuration bus
  typedef logic [1:0] cfgAddr_t;
  typedef logic [7:0] cfgData_t;

  // number of frames between blink toggles, 0 keeps the banner on
  typedef logic [3:0] blinkPeriod_t;

  // register map
  localparam cfgAddr_t addrEnable = 2'd0;
  localparam cfgAddr_t addrBoomColor = 2'd1;
  localparam cfgAddr_t addrBgColor = 2'd2;
  localparam cfgAddr_t addrBlinkPeriod = 2'd3;

  // reset values of the registers
  localparam color_t resetBoomColor = 3'd7;
  localparam color_t resetBgColor = 3'd0;
  localparam blinkPeriod_t resetBlinkPeriod = 4'd0;

endpackage

`default_nettype wire

// File: boom_config.svh
`ifndef BOOM_CONFIG_SVH
`define BOOM_CONFIG_SVH

// visible area in pixels and lines
`define H_ACTIVE 320
`define V_ACTIVE 240

// full line length in clocks, full frame length in lines
`define H_TOTAL 352
`define V_TOTAL 250

// hsync is low for HSYNC_LEN clocks starting at column HSYNC_START
`define HSYNC_START 328
`define HSYNC_LEN 16

// vsync is low for VSYNC_LEN whole lines starting at line VSYNC_START
`define VSYNC_START 243
`define VSYNC_LEN 3

// top left corner of the banner artwork
`define BOOM_X0 82
`define BOOM_Y0 96

`endif
